// File: source/cache_pkg.sv
package cache_pkg;

    localparam int addr_w         = 16;
    localparam int data_w         = 16;
    localparam int offset_w       = 3;  // byte offset within a line
    localparam int words_per_line = 4;

    // the low two bits of the wb and fill states give the line word
    // that the state works on
    typedef enum logic [3:0] {
        idle   = 4'h0,
        comp   = 4'h1,
        done   = 4'h2,
        wb_0   = 4'h4,
        wb_1   = 4'h5,
        wb_2   = 4'h6,
        wb_3   = 4'h7,
        fill_0 = 4'h8,  // read word 0
        fill_1 = 4'h9,
        fill_2 = 4'ha,  // word 0 back, read word 2
        fill_3 = 4'hb,
        fill_4 = 4'hc,
        fill_5 = 4'hd   // last word written, done
    } cntrl_state_e;

endpackage

// File: source/cache_array.sv
`timescale 1ns/10ps

module cache_array
    import cache_pkg::*;
#(
    parameter int index_w = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  en,
    input  logic                                  comp,
    input  logic                                  write,
    input  logic                                  valid_in,
    input  logic [index_w-1:0]                    index,
    input  logic [offset_w-1:0]                   offset,
    input  logic [addr_w-index_w-offset_w-1:0]    tag,
    input  logic [data_w-1:0]                     wdata,
    output logic                                  hit,
    output logic                                  valid,
    output logic                                  dirty,
    output logic [addr_w-index_w-offset_w-1:0]    tag_out,
    output logic [data_w-1:0]                     rdata
);

    localparam int tag_w  = addr_w - index_w - offset_w;
    localparam int lines  = 2 ** index_w;
    localparam int word_w = $clog2(words_per_line);

    logic [lines-1:0]      valid_q;
    logic [lines-1:0]      dirty_q;
    logic [tag_w-1:0]      tag_mem  [lines];
    logic [data_w-1:0]     data_mem [lines * words_per_line];

    logic [index_w+word_w-1:0] word_addr;
    logic                      wr_en;

    assign word_addr = {index, offset[offset_w-1:1]};  // offset bit 0 is the byte in the word

    assign valid   = valid_q[index];
    assign dirty   = dirty_q[index];
    assign tag_out = tag_mem[index];
    assign rdata   = data_mem[word_addr];
    assign hit     = en & valid & (tag_out == tag);

    // a compare write only lands on a hit, a fill write always lands
    assign wr_en = en & write & (~comp | hit);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            if (comp) begin
                dirty_q[index] <= 1'b1;
            end else begin
                valid_q[index] <= valid_in;
                dirty_q[index] <= 1'b0;  // line now matches memory
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && !comp) begin
            tag_mem[index] <= tag;
        end
        if (wr_en) begin
            data_mem[word_addr] <= wdata;
        end
    end

endmodule

// File: source/cache_cntrl.sv
`timescale 1ns/10ps

module cache_cntrl
    import cache_pkg::*;
#(
    parameter int index_w = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  rd,
    input  logic                                  wr,
    input  logic [addr_w-1:0]                     addr,
    input  logic [data_w-1:0]                     data_in,
    output logic [data_w-1:0]                     data_out,
    output logic                                  done,
    output logic                                  stall,
    output logic                                  cache_hit,
    output logic                                  arr_en,
    output logic                                  arr_comp,
    output logic                                  arr_write,
    output logic                                  arr_valid_in,
    output logic [index_w-1:0]                    arr_index,
    output logic [offset_w-1:0]                   arr_offset,
    output logic [addr_w-index_w-offset_w-1:0]    arr_tag,
    output logic [data_w-1:0]                     arr_wdata,
    input  logic                                  arr_hit,
    input  logic                                  arr_valid,
    input  logic                                  arr_dirty,
    input  logic [addr_w-index_w-offset_w-1:0]    arr_tag_out,
    input  logic [data_w-1:0]                     arr_rdata,
    output logic [addr_w-1:0]                     mem_addr,
    output logic [data_w-1:0]                     mem_wdata,
    output logic                                  mem_write,
    output logic                                  mem_read,
    input  logic [data_w-1:0]                     mem_rdata
);

    localparam int tag_w = addr_w - index_w - offset_w;

    cntrl_state_e state;
    cntrl_state_e nxt_state;

    logic               rd_q;       // accepted request was a read
    logic               wr_q;       // accepted request was a write
    logic [data_w-1:0]  data_q;

    logic [index_w-1:0] index;
    logic [tag_w-1:0]   tag;
    logic [1:0]         req_word;
    logic [1:0]         st_word;
    logic [1:0]         fill_word;
    logic               is_wb;
    logic               fill_rd;
    logic               fill_wr;
    logic               capture;

    assign index    = addr[offset_w +: index_w];
    assign tag      = addr[addr_w-1 -: tag_w];
    assign req_word = addr[offset_w-1:1];

    assign st_word   = state[1:0];
    assign fill_word = st_word - 2'd2;  // returning data lags the read by two states

    assign arr_index = index;
    assign arr_tag   = tag;
    assign mem_wdata = arr_rdata;       // write-back streams the old line out

    always_comb begin
        nxt_state    = state;
        stall        = 1'b1;
        done         = 1'b0;
        arr_en       = 1'b0;
        arr_comp     = 1'b0;
        arr_write    = 1'b0;
        arr_valid_in = 1'b0;
        arr_offset   = addr[offset_w-1:0];
        arr_wdata    = data_in;
        mem_write    = 1'b0;
        mem_read     = 1'b0;
        is_wb        = 1'b0;
        fill_rd      = 1'b0;
        fill_wr      = 1'b0;

        case (state)
            idle: begin
                stall = 1'b0;
                if (rd || wr) begin
                    nxt_state = comp;
                end
            end
            comp: begin
                arr_en    = 1'b1;
                arr_comp  = 1'b1;
                arr_write = wr_q;
                if (arr_hit) begin
                    nxt_state = cache_pkg::done;  // the port shares this name
                end else if (arr_valid && arr_dirty) begin
                    nxt_state = wb_0;
                end else begin
                    nxt_state = fill_0;
                end
            end
            wb_0, wb_1, wb_2, wb_3: begin
                is_wb      = 1'b1;
                arr_en     = 1'b1;
                arr_offset = {st_word, 1'b0};
                mem_write  = 1'b1;
                nxt_state  = cntrl_state_e'(state + 4'd1);  // wb_3 runs into fill_0
            end
            fill_0, fill_1: begin
                fill_rd   = 1'b1;
                nxt_state = cntrl_state_e'(state + 4'd1);
            end
            fill_2, fill_3: begin
                fill_rd   = 1'b1;
                fill_wr   = 1'b1;
                nxt_state = cntrl_state_e'(state + 4'd1);
            end
            fill_4: begin
                fill_wr   = 1'b1;
                nxt_state = fill_5;
            end
            fill_5: begin
                fill_wr   = 1'b1;
                done      = 1'b1;
                nxt_state = idle;
            end
            cache_pkg::done: begin
                done      = 1'b1;
                nxt_state = idle;
            end
            default: begin
                nxt_state = idle;
            end
        endcase

        if (fill_wr) begin
            arr_en       = 1'b1;
            arr_write    = 1'b1;
            arr_valid_in = 1'b1;
            arr_offset   = {fill_word, 1'b0};
            if (!(wr_q && fill_word == req_word)) begin
                arr_wdata = mem_rdata;  // request word keeps data_in on a write miss
            end
            // the last fill word of a write miss goes in as a compare write
            // so the merged line ends up dirty
            arr_comp = wr_q & (state == fill_5);
        end

        if (fill_rd) begin
            mem_read = 1'b1;
        end
        mem_addr = {is_wb ? arr_tag_out : tag, index, st_word, 1'b0};
    end

    assign capture   = fill_wr & rd_q & (fill_word == req_word);
    assign data_out  = capture ? mem_rdata : data_q;  // word 3 only arrives in fill_5
    assign cache_hit = (state == cache_pkg::done);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
            rd_q  <= 1'b0;
            wr_q  <= 1'b0;
        end else begin
            state <= nxt_state;
            if (state == idle) begin
                rd_q <= rd;
                wr_q <= wr & ~rd;  // read wins if both are up
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == comp) begin
            data_q <= arr_rdata;
        end else if (capture) begin
            data_q <= mem_rdata;
        end
    end

endmodule

// File: source/main_mem.sv
`timescale 1ns/10ps

module main_mem
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [addr_w-1:0]   addr,
    input  logic [data_w-1:0]   wdata,
    input  logic                write,
    input  logic                read,
    output logic [data_w-1:0]   rdata
);

    localparam int depth = 2 ** (addr_w - 1);  // one entry per 16-bit word

    logic [data_w-1:0] mem [depth];

    logic [addr_w-2:0] rd_addr_q;   // stage 1
    logic [data_w-1:0] rd_data_q;   // stage 2
    logic              rd_v1;
    logic              rd_v2;

    // word at word address a holds a ^ 16'h5a5a
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = data_w'(i) ^ 16'h5a5a;
        end
    end

    always @(posedge clk) begin
        if (write) begin
            mem[addr[addr_w-1:1]] <= wdata;
        end
        if (read) begin
            rd_addr_q <= addr[addr_w-1:1];
        end
        if (rd_v1) begin
            rd_data_q <= mem[rd_addr_q];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_v1 <= 1'b0;
            rd_v2 <= 1'b0;
        end else begin
            rd_v1 <= read;
            rd_v2 <= rd_v1;
        end
    end

    assign rdata = rd_v2 ? rd_data_q : '0;  // quiet between reads

endmodule

// File: source/mem_system.sv
`timescale 1ns/10ps

module mem_system
    import cache_pkg::*;
#(
    parameter int index_w = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rd,
    input  logic                wr,
    input  logic [addr_w-1:0]   addr,
    input  logic [data_w-1:0]   data_in,
    output logic [data_w-1:0]   data_out,
    output logic                done,
    output logic                stall,
    output logic                cache_hit
);

    localparam int tag_w = addr_w - index_w - offset_w;

    logic                arr_en;
    logic                arr_comp;
    logic                arr_write;
    logic                arr_valid_in;
    logic [index_w-1:0]  arr_index;
    logic [offset_w-1:0] arr_offset;
    logic [tag_w-1:0]    arr_tag;
    logic [data_w-1:0]   arr_wdata;
    logic                arr_hit;
    logic                arr_valid;
    logic                arr_dirty;
    logic [tag_w-1:0]    arr_tag_out;
    logic [data_w-1:0]   arr_rdata;

    logic [addr_w-1:0]   mem_addr;
    logic [data_w-1:0]   mem_wdata;
    logic                mem_write;
    logic                mem_read;
    logic [data_w-1:0]   mem_rdata;

    cache_cntrl #(
        .index_w (index_w)
    ) i_cache_cntrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd           (rd),
        .wr           (wr),
        .addr         (addr),
        .data_in      (data_in),
        .data_out     (data_out),
        .done         (done),
        .stall        (stall),
        .cache_hit    (cache_hit),
        .arr_en       (arr_en),
        .arr_comp     (arr_comp),
        .arr_write    (arr_write),
        .arr_valid_in (arr_valid_in),
        .arr_index    (arr_index),
        .arr_offset   (arr_offset),
        .arr_tag      (arr_tag),
        .arr_wdata    (arr_wdata),
        .arr_hit      (arr_hit),
        .arr_valid    (arr_valid),
        .arr_dirty    (arr_dirty),
        .arr_tag_out  (arr_tag_out),
        .arr_rdata    (arr_rdata),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_write    (mem_write),
        .mem_read     (mem_read),
        .mem_rdata    (mem_rdata)
    );

    cache_array #(
        .index_w (index_w)
    ) i_cache_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (arr_en),
        .comp     (arr_comp),
        .write    (arr_write),
        .valid_in (arr_valid_in),
        .index    (arr_index),
        .offset   (arr_offset),
        .tag      (arr_tag),
        .wdata    (arr_wdata),
        .hit      (arr_hit),
        .valid    (arr_valid),
        .dirty    (arr_dirty),
        .tag_out  (arr_tag_out),
        .rdata    (arr_rdata)
    );

    main_mem i_main_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .write (mem_write),
        .read  (mem_read),
        .rdata (mem_rdata)
    );

endmodule

// File: dv/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;  // released on a rising edge like the other inputs
    end

endmodule

// File: dv/tb_mem_system.sv
`timescale 1ns/10ps

module tb_mem_system;

    localparam int index_w      = 8;
    localparam int clk_period   = 20;
    localparam int reset_cycles = 8;
    localparam int n_ops        = 16;
    localparam int max_latency  = 11;
    localparam int timeout_cycles = n_ops * (max_latency + 2) + reset_cycles + 40;

    logic        clk;
    logic        rst_n;
    logic        rd;
    logic        wr;
    logic [15:0] addr;
    logic [15:0] data_in;
    logic [15:0] data_out;
    logic        done;
    logic        stall;
    logic        cache_hit;

    // operation table
    logic        op_wr    [n_ops];
    logic [15:0] op_addr  [n_ops];
    logic [15:0] op_wdata [n_ops];
    logic        op_hit   [n_ops];
    int          op_lat   [n_ops];

    logic [15:0] shadow [logic [14:0]];  // words written so far, by word address

    clk_gen #(
        .period_ns    (clk_period),
        .reset_cycles (reset_cycles)
    ) i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_system #(
        .index_w (index_w)
    ) i_mem_system (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd        (rd),
        .wr        (wr),
        .addr      (addr),
        .data_in   (data_in),
        .data_out  (data_out),
        .done      (done),
        .stall     (stall),
        .cache_hit (cache_hit)
    );

    function automatic logic [15:0] make_addr(input int tag, input int index, input int word);
        return 16'((tag << (index_w + 3)) | (index << 3) | (word << 1));
    endfunction

    // memory starts as word address xor 16'h5a5a
    function automatic logic [15:0] expected_word(input logic [15:0] a);
        logic [14:0] wa;
        wa = a[15:1];
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end
        return {1'b0, wa} ^ 16'h5a5a;
    endfunction

    task automatic set_op(input int idx, input logic is_wr, input logic [15:0] a,
                          input logic hit, input int lat);
        op_wr[idx]    = is_wr;
        op_addr[idx]  = a;
        op_wdata[idx] = is_wr ? 16'($urandom) : 16'h0000;
        op_hit[idx]   = hit;
        op_lat[idx]   = lat;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic build_table();
        set_op(0,  1'b0, make_addr(1, 'h12, 0), 1'b0, 7);   // cold read miss
        set_op(1,  1'b0, make_addr(1, 'h12, 2), 1'b1, 2);
        set_op(2,  1'b1, make_addr(1, 'h12, 1), 1'b1, 2);   // write hit, line dirty
        set_op(3,  1'b0, make_addr(1, 'h12, 1), 1'b1, 2);
        set_op(4,  1'b1, make_addr(2, 'h34, 3), 1'b0, 7);   // write miss, merged in fill
        set_op(5,  1'b0, make_addr(2, 'h34, 3), 1'b1, 2);
        set_op(6,  1'b0, make_addr(2, 'h34, 0), 1'b1, 2);
        set_op(7,  1'b0, make_addr(2, 'h34, 1), 1'b1, 2);
        set_op(8,  1'b0, make_addr(2, 'h34, 2), 1'b1, 2);
        set_op(9,  1'b0, make_addr(3, 'h12, 2), 1'b0, 11);  // evicts dirty tag 1
        set_op(10, 1'b0, make_addr(1, 'h12, 1), 1'b0, 7);   // written-back word
        set_op(11, 1'b0, make_addr(1, 'h12, 0), 1'b1, 2);
        set_op(12, 1'b1, make_addr(6, 'h34, 1), 1'b0, 11);  // write miss on dirty line
        set_op(13, 1'b0, make_addr(2, 'h34, 3), 1'b0, 11);
        set_op(14, 1'b0, make_addr(6, 'h34, 1), 1'b0, 7);
        set_op(15, 1'b0, make_addr(6, 'h34, 0), 1'b1, 2);
    endtask

    initial begin
        int cycles;
        int lat;

        rd      = 1'b0;
        wr      = 1'b0;
        addr    = '0;
        data_in = '0;
        void'($urandom(32'hea7f_71e5));
        build_table();

        @(posedge rst_n);
        @(negedge clk);
        check_value("stall", 32'(stall), 32'h0);
        check_value("done", 32'(done), 32'h0);
        check_value("cache_hit", 32'(cache_hit), 32'h0);

        for (int i = 0; i < n_ops; i++) begin
            @(posedge clk);
            rd      <= ~op_wr[i];
            wr      <= op_wr[i];
            addr    <= op_addr[i];
            data_in <= op_wdata[i];

            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
                if (cycles == 1) begin
                    check_value("done", 32'(done), 32'h0);  // previous done lasted one cycle
                    check_value("stall", 32'(stall), 32'h0);
                end else if (!done) begin
                    check_value("stall", 32'(stall), 32'h1);  // busy until done
                end
            end while (!done);
            lat = cycles - 1;  // first negedge is still in idle

            check_value("latency", 32'(lat), 32'(op_lat[i]));
            check_value("cache_hit", 32'(cache_hit), 32'(op_hit[i]));
            if (op_wr[i]) begin
                shadow[op_addr[i][15:1]] = op_wdata[i];
            end else begin
                check_value("data_out", 32'(data_out), 32'(expected_word(op_addr[i])));
            end
        end

        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;
        repeat (2) @(posedge clk);

        $display("Test OK");
        $finish;
    end

    initial begin
        #(timeout_cycles * clk_period);
        $display("Timeout: done never arrived for a request");
        $display("Test FAILED");
        $fatal(1);
    end

endmodule

// File: sim.f
source/cache_pkg.sv
source/cache_array.sv
source/cache_cntrl.sv
source/main_mem.sv
source/mem_system.sv
dv/clk_gen.sv
dv/tb_mem_system.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_mem_system -o sim_tb

# the simulator exits non-zero on a failure, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if ! grep -q "Test OK" sim.log; then
    echo "simulation ended without a pass line"
    exit 1
fi

exit 0
